//--- design/lcd_pkg.sv
package lcd_pkg;

    // panel timing and sizes
    // reset hold is kept short so simulation reaches the init sequence quickly
    localparam int HARD_RESET_CYCLES = 64;
    // table entries ahead of the end marker
    localparam int INIT_LEN = 9;
    localparam int FIFO_DEPTH = 4;

    // panel data bus value
    typedef logic [15:0] lcd_data_t;

    // closes the init sequence
    localparam lcd_data_t CMD_DISPLAY_ON = 16'h0029;

    // word kind, only INST and DATA reach the panel
    typedef enum logic [1:0] {
        LCD_KIND_NONE = 2'd0,
        LCD_KIND_INST = 2'd1,
        LCD_KIND_DATA = 2'd2,
        LCD_KIND_RSVD = 2'd3
    } lcd_kind_e;

    // one panel word as it travels host -> fifo -> bus
    typedef struct packed {
        lcd_kind_e kind;
        lcd_data_t data;
    } lcd_word_t;

    // init rom address
    typedef logic [3:0] rom_addr_t;

    // panel reset hold counter
    typedef logic [$clog2(HARD_RESET_CYCLES)-1:0] hold_cnt_t;

    // fifo pointers and fill level
    typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_cnt_t;

    // sequencer states
    typedef enum logic [2:0] {
        S_RESET_HOLD = 3'd0,
        S_INIT_READ  = 3'd1,
        S_INIT_PUSH  = 3'd2,
        S_DISPLAY_ON = 3'd3,
        S_RUN        = 3'd4
    } seq_state_e;

    // end of the init table
    localparam lcd_word_t LCD_WORD_END = '{
        kind: LCD_KIND_NONE,
        data: 16'h0000
    };

    // last word of the init sequence
    localparam lcd_word_t LCD_WORD_DISPLAY_ON = '{
        kind: LCD_KIND_INST,
        data: CMD_DISPLAY_ON
    };

endpackage

//--- design/lcd_init_rom.sv
module lcd_init_rom (
    input  logic               clk,
    input  lcd_pkg::rom_addr_t addr_i,
    output lcd_pkg::lcd_word_t word_o
);
    import lcd_pkg::*;

    // registered read, word is valid one cycle after the address
    always_ff @(posedge clk) begin
        if (addr_i >= rom_addr_t'(INIT_LEN)) begin
            word_o <= LCD_WORD_END;
        end else begin
            case (addr_i)
                // sleep out
                4'd0: begin
                    word_o <= '{kind: LCD_KIND_INST, data: 16'h0011};
                end
                // pixel format, 16 bpp
                4'd1: begin
                    word_o <= '{kind: LCD_KIND_INST, data: 16'h003A};
                end
                4'd2: begin
                    word_o <= '{kind: LCD_KIND_DATA, data: 16'h0055};
                end
                // memory access control
                4'd3: begin
                    word_o <= '{kind: LCD_KIND_INST, data: 16'h0036};
                end
                4'd4: begin
                    word_o <= '{kind: LCD_KIND_DATA, data: 16'h0048};
                end
                // column range
                4'd5: begin
                    word_o <= '{kind: LCD_KIND_INST, data: 16'h002A};
                end
                4'd6: begin
                    word_o <= '{kind: LCD_KIND_DATA, data: 16'h0000};
                end
                4'd7: begin
                    word_o <= '{kind: LCD_KIND_DATA, data: 16'h013F};
                end
                // normal display mode
                4'd8: begin
                    word_o <= '{kind: LCD_KIND_INST, data: 16'h0013};
                end
                default: begin
                    word_o <= LCD_WORD_END;
                end
            endcase
        end
    end

endmodule

//--- design/lcd_cmd_sequencer.sv
module lcd_cmd_sequencer (
    input  logic               clk,
    input  logic               resetn,

    // host command stream
    input  logic               host_valid_i,
    input  lcd_pkg::lcd_word_t host_word_i,
    output logic               host_ready_o,

    // init rom
    output lcd_pkg::rom_addr_t rom_addr_o,
    input  lcd_pkg::lcd_word_t rom_word_i,

    // fifo push side
    output logic               push_valid_o,
    output lcd_pkg::lcd_word_t push_word_o,
    input  logic               push_ready_i,

    output logic               lcd_rst_o,
    output logic               busy_o
);
    import lcd_pkg::*;

    seq_state_e state_q;
    hold_cnt_t  hold_cnt_q;
    rom_addr_t  rom_addr_q;
    logic       host_kind_ok;
    logic       rom_at_end;

    // only instruction and data words go to the panel
    assign host_kind_ok = (host_word_i.kind == LCD_KIND_INST) ||
                          (host_word_i.kind == LCD_KIND_DATA);

    assign rom_at_end = (rom_word_i.kind == LCD_KIND_NONE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q    <= S_RESET_HOLD;
            hold_cnt_q <= '0;
            rom_addr_q <= '0;
        end else begin
            case (state_q)
                S_RESET_HOLD: begin
                    hold_cnt_q <= hold_cnt_q + 1'b1;
                    if (hold_cnt_q == hold_cnt_t'(HARD_RESET_CYCLES - 1)) begin
                        state_q <= S_INIT_READ;
                    end
                end
                // rom registers the word at rom_addr_q this cycle
                S_INIT_READ: begin
                    state_q <= S_INIT_PUSH;
                end
                S_INIT_PUSH: begin
                    if (rom_at_end) begin
                        state_q <= S_DISPLAY_ON;
                    end else if (push_ready_i) begin
                        rom_addr_q <= rom_addr_q + 1'b1;
                        state_q    <= S_INIT_READ;
                    end
                end
                S_DISPLAY_ON: begin
                    if (push_ready_i) begin
                        state_q <= S_RUN;
                    end
                end
                S_RUN: begin
                    state_q <= S_RUN;
                end
                default: begin
                    state_q <= S_RESET_HOLD;
                end
            endcase
        end
    end

    // panel held in reset until the hold counter expires
    assign lcd_rst_o  = (state_q != S_RESET_HOLD);
    assign busy_o     = (state_q != S_RUN);
    assign rom_addr_o = rom_addr_q;

    always_comb begin
        push_valid_o = 1'b0;
        push_word_o  = rom_word_i;
        host_ready_o = 1'b0;
        case (state_q)
            S_INIT_PUSH: begin
                push_valid_o = !rom_at_end;
            end
            S_DISPLAY_ON: begin
                push_valid_o = 1'b1;
                push_word_o  = LCD_WORD_DISPLAY_ON;
            end
            S_RUN: begin
                // bad kinds are taken from the host but never pushed
                host_ready_o = push_ready_i;
                push_valid_o = host_valid_i && host_kind_ok;
                push_word_o  = host_word_i;
            end
            default: begin
                push_valid_o = 1'b0;
            end
        endcase
    end

endmodule

//--- design/lcd_cmd_fifo.sv
module lcd_cmd_fifo (
    input  logic               clk,
    input  logic               resetn,

    input  logic               push_valid_i,
    input  lcd_pkg::lcd_word_t push_word_i,
    output logic               push_ready_o,

    output logic               pop_valid_o,
    output lcd_pkg::lcd_word_t pop_word_o,
    input  logic               pop_ready_i
);
    import lcd_pkg::*;

    lcd_word_t mem_q [FIFO_DEPTH];
    fifo_ptr_t wr_ptr_q;
    fifo_ptr_t rd_ptr_q;
    fifo_cnt_t count_q;
    logic      full_q;
    logic      empty_q;
    logic      do_push;
    logic      do_pop;

    function automatic fifo_ptr_t next_ptr(input fifo_ptr_t ptr);
        if (ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // a full fifo still takes a word when the writer pops in the same cycle
    assign push_ready_o = !full_q || pop_ready_i;
    assign pop_valid_o  = !empty_q;
    assign pop_word_o   = mem_q[rd_ptr_q];

    assign do_push = push_valid_i && push_ready_o;
    assign do_pop  = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_word_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            full_q   <= 1'b0;
            empty_q  <= 1'b1;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // fill level only moves when one side is idle
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
                empty_q <= 1'b0;
                full_q  <= (count_q == fifo_cnt_t'(FIFO_DEPTH - 1));
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
                full_q  <= 1'b0;
                empty_q <= (count_q == fifo_cnt_t'(1));
            end
        end
    end

endmodule

//--- design/lcd_bus_writer.sv
module lcd_bus_writer (
    input  logic               clk,
    input  logic               resetn,

    input  logic               pop_valid_i,
    input  lcd_pkg::lcd_word_t pop_word_i,
    output logic               pop_ready_o,

    // panel bus
    output logic               lcd_rs_o,
    output logic               lcd_wr_o,
    output lcd_pkg::lcd_data_t lcd_data_o
);
    import lcd_pkg::*;

    // idle cycle doubles as the strobe high time
    typedef enum logic {
        PH_IDLE   = 1'b0,
        PH_STROBE = 1'b1
    } wr_phase_e;

    wr_phase_e phase_q;
    lcd_data_t data_q;
    logic      rs_q;
    logic      accept;

    assign pop_ready_o = (phase_q == PH_IDLE);
    assign accept      = pop_valid_i && pop_ready_o;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            phase_q <= PH_IDLE;
            rs_q    <= 1'b0;
        end else begin
            case (phase_q)
                PH_IDLE: begin
                    if (accept) begin
                        phase_q <= PH_STROBE;
                        // rs high selects pixel data
                        rs_q    <= (pop_word_i.kind == LCD_KIND_DATA);
                    end
                end
                PH_STROBE: begin
                    // wr rises here, panel latches data and rs
                    phase_q <= PH_IDLE;
                end
                default: begin
                    phase_q <= PH_IDLE;
                end
            endcase
        end
    end

    // data holds past the wr rising edge until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= pop_word_i.data;
        end
    end

    // wr low for exactly the strobe phase
    assign lcd_wr_o   = (phase_q != PH_STROBE);
    assign lcd_rs_o   = rs_q;
    assign lcd_data_o = data_q;

endmodule

//--- design/lcd_top.sv
module lcd_top (
    input  logic               clk,
    input  logic               resetn,

    input  logic               host_valid_i,
    input  lcd_pkg::lcd_word_t host_word_i,
    output logic               host_ready_o,
    output logic               busy_o,

    output logic               lcd_rst_o,
    output logic               lcd_rs_o,
    output logic               lcd_wr_o,
    output lcd_pkg::lcd_data_t lcd_data_o
);
    import lcd_pkg::*;

    rom_addr_t rom_addr;
    lcd_word_t rom_word;

    // sequencer to fifo
    logic      push_valid;
    lcd_word_t push_word;
    logic      push_ready;

    // fifo to bus writer
    logic      pop_valid;
    lcd_word_t pop_word;
    logic      pop_ready;

    lcd_init_rom lcd_init_rom_inst (
        .clk    (clk),
        .addr_i (rom_addr),
        .word_o (rom_word)
    );

    lcd_cmd_sequencer lcd_cmd_sequencer_inst (
        .clk          (clk),
        .resetn       (resetn),
        .host_valid_i (host_valid_i),
        .host_word_i  (host_word_i),
        .host_ready_o (host_ready_o),
        .rom_addr_o   (rom_addr),
        .rom_word_i   (rom_word),
        .push_valid_o (push_valid),
        .push_word_o  (push_word),
        .push_ready_i (push_ready),
        .lcd_rst_o    (lcd_rst_o),
        .busy_o       (busy_o)
    );

    lcd_cmd_fifo lcd_cmd_fifo_inst (
        .clk          (clk),
        .resetn       (resetn),
        .push_valid_i (push_valid),
        .push_word_i  (push_word),
        .push_ready_o (push_ready),
        .pop_valid_o  (pop_valid),
        .pop_word_o   (pop_word),
        .pop_ready_i  (pop_ready)
    );

    lcd_bus_writer lcd_bus_writer_inst (
        .clk         (clk),
        .resetn      (resetn),
        .pop_valid_i (pop_valid),
        .pop_word_i  (pop_word),
        .pop_ready_o (pop_ready),
        .lcd_rs_o    (lcd_rs_o),
        .lcd_wr_o    (lcd_wr_o),
        .lcd_data_o  (lcd_data_o)
    );

endmodule

//--- tb/lcd_top_sva.sv
module lcd_top_sva (
    input logic                   clk,
    input logic                   resetn,
    input logic                   host_valid_i,
    input logic                   host_ready_o,
    input lcd_pkg::lcd_word_t     host_word_i,
    input logic                   push_valid,
    input logic                   push_ready,
    input lcd_pkg::lcd_word_t     push_word,
    input logic                   pop_valid,
    input logic                   pop_ready,
    input lcd_pkg::lcd_word_t     pop_word,
    input logic                   lcd_wr_o,
    input lcd_pkg::seq_state_e    state
);
    timeunit 1ns;
    timeprecision 1ps;
    import lcd_pkg::*;

    // offered words hold until taken
    host_hold: assert property (@(posedge clk) disable iff (!resetn)
        host_valid_i && !host_ready_o |=> host_valid_i && $stable(host_word_i))
        else $error("host word changed before it was taken");

    push_hold: assert property (@(posedge clk) disable iff (!resetn)
        push_valid && !push_ready |=> push_valid && $stable(push_word))
        else $error("push word changed before it was taken");

    pop_hold: assert property (@(posedge clk) disable iff (!resetn)
        pop_valid && !pop_ready |=> pop_valid && $stable(pop_word))
        else $error("pop word changed before it was taken");

    // strobe is a single low cycle
    wr_single: assert property (@(posedge clk) disable iff (!resetn)
        !lcd_wr_o |=> lcd_wr_o)
        else $error("write strobe low for two cycles");

    ready_run_only: assert property (@(posedge clk) disable iff (!resetn)
        state != S_RUN |-> !host_ready_o)
        else $error("host ready outside run state");

endmodule

bind lcd_top lcd_top_sva lcd_top_sva_inst (
    .clk          (clk),
    .resetn       (resetn),
    .host_valid_i (host_valid_i),
    .host_ready_o (host_ready_o),
    .host_word_i  (host_word_i),
    .push_valid   (push_valid),
    .push_ready   (push_ready),
    .push_word    (push_word),
    .pop_valid    (pop_valid),
    .pop_ready    (pop_ready),
    .pop_word     (pop_word),
    .lcd_wr_o     (lcd_wr_o),
    .state        (lcd_cmd_sequencer_inst.state_q)
);

//--- tb/tb_lcd_top.sv
module tb_lcd_top;
    timeunit 1ns;
    timeprecision 1ps;
    import lcd_pkg::*;

    localparam int RANDOM_WORDS = 80;
    localparam int BURST_WORDS = 40;
    localparam int HOST_WORDS = RANDOM_WORDS + BURST_WORDS;
    localparam int CYCLE_LIMIT = 4 * (HARD_RESET_CYCLES + 2 * (INIT_LEN + 1 + HOST_WORDS) + 100);

    logic               clk;
    logic               resetn;
    logic               host_valid_i;
    lcd_word_t          host_word_i;
    logic               host_ready_o;
    logic               busy_o;
    logic               lcd_rst_o;
    logic               lcd_rs_o;
    logic               lcd_wr_o;
    lcd_data_t          lcd_data_o;

    lcd_word_t expected[$];
    int        errors;
    int        checks;
    int        strobes;
    int        dropped;
    int        stalls;
    int        wr_faults;
    int        cycles;
    logic      wr_prev;

    lcd_top lcd_top_inst (
        .clk          (clk),
        .resetn       (resetn),
        .host_valid_i (host_valid_i),
        .host_word_i  (host_word_i),
        .host_ready_o (host_ready_o),
        .busy_o       (busy_o),
        .lcd_rst_o    (lcd_rst_o),
        .lcd_rs_o     (lcd_rs_o),
        .lcd_wr_o     (lcd_wr_o),
        .lcd_data_o   (lcd_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // bus monitor, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        lcd_word_t exp_w;
        if (resetn) begin
            assert (!(wr_prev == 1'b0 && lcd_wr_o == 1'b0)) else begin
                $display("write strobe stayed low for two cycles at %0t", $time);
                wr_faults++;
            end
            if (wr_prev == 1'b0 && lcd_wr_o == 1'b1) begin
                strobes++;
                if (expected.size() == 0) begin
                    $display("strobe at %0t with no expected word, data %h", $time, lcd_data_o);
                    errors++;
                end else begin
                    exp_w = expected.pop_front();
                    checks += 2;
                    assert (lcd_data_o == exp_w.data) else begin
                        $display("Mismatch at %0t: lcd_data_o got %h expected %h",
                                 $time, lcd_data_o, exp_w.data);
                        errors++;
                    end
                    assert (lcd_rs_o == (exp_w.kind == LCD_KIND_DATA)) else begin
                        $display("Mismatch at %0t: lcd_rs_o got %b expected %b",
                                 $time, lcd_rs_o, exp_w.kind == LCD_KIND_DATA);
                        errors++;
                    end
                end
            end
            if (!busy_o && host_valid_i && !host_ready_o) begin
                stalls++;
            end
        end
        wr_prev = lcd_wr_o;
    end

    function automatic lcd_word_t random_word();
        lcd_word_t w;
        w.data = lcd_data_t'($urandom);
        if ($urandom_range(7) == 0) begin
            w.kind = ($urandom_range(1) == 0) ? LCD_KIND_NONE : LCD_KIND_RSVD;
        end else begin
            w.kind = ($urandom_range(1) == 0) ? LCD_KIND_INST : LCD_KIND_DATA;
        end
        return w;
    endfunction

    // called right after a rising edge
    task automatic send_words(input int n, input int gap_pct);
        int        sent;
        logic      taken;
        lcd_word_t w;
        sent = 0;
        while (sent < n) begin
            if ($urandom_range(99) < gap_pct) begin
                host_valid_i <= 1'b0;
                @(posedge clk);
            end else begin
                w = random_word();
                host_valid_i <= 1'b1;
                host_word_i  <= w;
                do begin
                    @(negedge clk);
                    taken = host_ready_o;
                    @(posedge clk);
                end while (!taken);
                if (w.kind == LCD_KIND_INST || w.kind == LCD_KIND_DATA) begin
                    expected.push_back(w);
                end else begin
                    dropped++;
                end
                sent++;
            end
        end
        host_valid_i <= 1'b0;
    endtask

    task automatic wait_drain();
        while (expected.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        int        low_cycles;
        int        errs_at;
        lcd_word_t table_w[INIT_LEN];
        void'($urandom(32'h2d8a_25b7));
        errors = 0;
        checks = 0;
        strobes = 0;
        dropped = 0;
        stalls = 0;
        wr_faults = 0;
        cycles = 0;
        wr_prev = 1'b1;
        resetn = 1'b0;
        host_valid_i = 1'b0;
        host_word_i = '0;

        // panel init table as the panel should see it
        table_w[0] = '{kind: LCD_KIND_INST, data: 16'h0011};
        table_w[1] = '{kind: LCD_KIND_INST, data: 16'h003A};
        table_w[2] = '{kind: LCD_KIND_DATA, data: 16'h0055};
        table_w[3] = '{kind: LCD_KIND_INST, data: 16'h0036};
        table_w[4] = '{kind: LCD_KIND_DATA, data: 16'h0048};
        table_w[5] = '{kind: LCD_KIND_INST, data: 16'h002A};
        table_w[6] = '{kind: LCD_KIND_DATA, data: 16'h0000};
        table_w[7] = '{kind: LCD_KIND_DATA, data: 16'h013F};
        table_w[8] = '{kind: LCD_KIND_INST, data: 16'h0013};
        foreach (table_w[i]) begin
            expected.push_back(table_w[i]);
        end
        expected.push_back('{kind: LCD_KIND_INST, data: 16'h0029});

        repeat (2) @(posedge clk);
        resetn <= 1'b1;

        // 1: panel reset hold
        errs_at = errors;
        low_cycles = 0;
        @(negedge clk);
        while (!lcd_rst_o) begin
            low_cycles++;
            checks += 3;
            assert (lcd_wr_o) else begin
                $display("Mismatch at %0t: lcd_wr_o got %b expected 1", $time, lcd_wr_o);
                errors++;
            end
            assert (busy_o) else begin
                $display("Mismatch at %0t: busy_o got %b expected 1", $time, busy_o);
                errors++;
            end
            assert (!host_ready_o) else begin
                $display("Mismatch at %0t: host_ready_o got %b expected 0",
                         $time, host_ready_o);
                errors++;
            end
            @(negedge clk);
        end
        checks++;
        assert (low_cycles == HARD_RESET_CYCLES) else begin
            $display("Mismatch at %0t: lcd_rst_o low cycles got %0d expected %0d",
                     $time, low_cycles, HARD_RESET_CYCLES);
            errors++;
        end
        report_test("reset_hold", errs_at);

        // 2: init sequence and display-on
        errs_at = errors;
        while (busy_o) begin
            @(posedge clk);
        end
        wait_drain();
        checks++;
        assert (strobes == INIT_LEN + 1) else begin
            $display("Mismatch at %0t: init strobes got %0d expected %0d",
                     $time, strobes, INIT_LEN + 1);
            errors++;
        end
        report_test("init_sequence", errs_at);

        // 3 and 4: random host words with gaps, bad kinds mixed in
        errs_at = errors;
        send_words(RANDOM_WORDS, 30);
        wait_drain();
        checks++;
        assert (dropped != 0) else begin
            $display("no invalid host word was generated");
            errors++;
        end
        report_test("random_host_words", errs_at);

        // 5: continuous burst
        errs_at = errors;
        stalls = 0;
        send_words(BURST_WORDS, 0);
        wait_drain();
        checks++;
        assert (stalls != 0) else begin
            $display("host ready never dropped during the burst");
            errors++;
        end
        report_test("burst_backpressure", errs_at);

        // 6: one low cycle per strobe, one strobe per expected word
        errs_at = errors;
        checks += 2;
        assert (wr_faults == 0) else begin
            $display("write strobe shape was broken %0d times", wr_faults);
            errors++;
        end
        assert (strobes == INIT_LEN + 1 + HOST_WORDS - dropped) else begin
            $display("Mismatch at %0t: strobe count got %0d expected %0d",
                     $time, strobes, INIT_LEN + 1 + HOST_WORDS - dropped);
            errors++;
        end
        report_test("strobe_shape", errs_at);

        $display("checks %0d, strobes %0d, dropped %0d, errors %0d",
                 checks, strobes, dropped, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
design/lcd_pkg.sv
design/lcd_init_rom.sv
design/lcd_cmd_sequencer.sv
design/lcd_cmd_fifo.sv
design/lcd_bus_writer.sv
design/lcd_top.sv
tb/lcd_top_sva.sv
tb/tb_lcd_top.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wall --top-module tb_lcd_top \
    -f filelist.f -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || \
    grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1
